/* hdl/cdd_pkg.sv */
// CD drive bridge shared widths, frame layout and encodings
`default_nettype none

package cdd_pkg;

	// Bytes per status or command frame
	localparam int FRAME_BYTES = 12;

	typedef logic [7:0] byte_t;

	// Byte 0 sits in bits 7:0
	typedef logic [FRAME_BYTES*8-1:0] frame_t;

	typedef logic [3:0] byte_idx_t;

	//////////////////////////////
	// Command opcodes
	//////////////////////////////
	typedef enum logic [7:0] {
		OP_NOP  = 8'h00,
		OP_PLAY = 8'h06,
		OP_SEEK = 8'h09
	} cdd_opcode_t;

	//////////////////////////////
	// Byte sequencer states
	//////////////////////////////
	typedef enum logic [1:0] {
		SEQ_IDLE = 2'd0,	// no exchange running
		SEQ_WAIT = 2'd1,	// request delay
		SEQ_XFER = 2'd2		// console clocking a byte
	} seq_state_t;

	// Command bytes replaced by the opcode counts
	localparam byte_idx_t CNT_PLAY_BYTE = 4'd9;
	localparam byte_idx_t CNT_SEEK_BYTE = 4'd8;

	// Audio flag, speed flag, then 16 data bits
	typedef logic [17:0] sector_word_t;

endpackage

`default_nettype wire

/* hdl/cdd_status_launch.sv */
// Status frame launcher, latches a new host frame and times the exchange start
`default_nettype none

module cdd_status_launch #(
	parameter int START_DELAY = 15
) (
	input  wire                 clk_sys,
	input  wire                 reset,
	input  wire cdd_pkg::frame_t status_frame,
	input  wire                 status_toggle,
	output cdd_pkg::frame_t     status_bytes,
	output logic                start
);

	localparam int CNT_W = $clog2(START_DELAY + 1);

	logic             last_toggle;
	logic [CNT_W-1:0] delay_cnt;
	logic             new_frame;

	assign new_frame = (status_toggle != last_toggle);

	// Toggle tracking and start delay
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_toggle <= 1'b0;
			delay_cnt <= '0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (new_frame) begin
				last_toggle <= status_toggle;
				delay_cnt <= CNT_W'(START_DELAY);
			end else if (delay_cnt != '0) begin
				delay_cnt <= delay_cnt - 1'b1;
				start <= (delay_cnt == CNT_W'(1));
			end
		end
	end

	// Frame held for the whole exchange
	always_ff @(posedge clk_sys) begin
		if (new_frame)
			status_bytes <= status_frame;
	end

endmodule

`default_nettype wire

/* hdl/cdd_bit_shifter.sv */
// CD link bit shifter, syncs comclk and moves one byte each way per transfer
`default_nettype none

module cdd_bit_shifter (
	input  wire                clk_sys,
	input  wire                reset,
	input  wire                clear,
	input  wire                load,
	input  wire cdd_pkg::byte_t tx_byte,
	input  wire                comclk,
	input  wire                hdata,
	output logic               cdata,
	output cdd_pkg::byte_t     rx_byte,
	output logic               rx_edge,
	output logic               byte_done
);

	import cdd_pkg::*;

	logic       comclk_s1;
	logic       comclk_s2;
	logic       comclk_d;
	logic       clk_rise;
	logic       clk_fall;
	byte_t      tx_shift;
	byte_t      rx_shift;
	logic [2:0] bit_cnt;

	//////////////////////////////
	// comclk sync and edges
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			comclk_s1 <= 1'b0;
			comclk_s2 <= 1'b0;
			comclk_d <= 1'b0;
		end else begin
			comclk_s1 <= comclk;
			comclk_s2 <= comclk_s1;
			comclk_d <= comclk_s2;
		end
	end

	assign clk_rise = comclk_s2 & ~comclk_d;
	assign clk_fall = ~comclk_s2 & comclk_d;

	//////////////////////////////
	// Shift and count
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cdata <= 1'b0;
			bit_cnt <= '0;
			rx_edge <= 1'b0;
			byte_done <= 1'b0;
		end else begin
			rx_edge <= 1'b0;
			byte_done <= 1'b0;
			if (clear) begin
				bit_cnt <= '0;
			end else if (clk_fall) begin
				// LSB first onto cdata
				cdata <= tx_shift[0];
			end else if (clk_rise) begin
				rx_edge <= 1'b1;
				bit_cnt <= bit_cnt + 3'd1;
				byte_done <= (bit_cnt == 3'd7);
			end
		end
	end

	// Payload shift registers
	always_ff @(posedge clk_sys) begin
		if (load)
			tx_shift <= tx_byte;
		else if (clk_fall && !clear)
			tx_shift <= {1'b0, tx_shift[7:1]};

		if (clk_rise && !clear)
			rx_shift <= {hdata, rx_shift[7:1]};
	end

	assign rx_byte = rx_shift;

	// Next byte loaded only once all eight bits of the last one are in
	a_load_on_byte_boundary: assert property (
		@(posedge clk_sys) disable iff (reset)
		load && !clear |-> (bit_cnt == 3'd0)
	) else $error("byte loaded before eight bits were clocked");

endmodule

`default_nettype wire

/* hdl/cdd_byte_sequencer.sv */
// CD link byte sequencer, walks the twelve bytes and drives request and sync
`default_nettype none

module cdd_byte_sequencer #(
	parameter int REQ_DELAY = 1023
) (
	input  wire                 clk_sys,
	input  wire                 reset,
	input  wire                 start,
	input  wire cdd_pkg::frame_t status_bytes,
	input  wire cdd_pkg::byte_t  rx_byte,
	input  wire                 rx_edge,
	input  wire                 byte_done,
	output logic                load,
	output logic                clear,
	output cdd_pkg::byte_t      tx_byte,
	output logic                comreq_n,
	output logic                comsync_n,
	output cdd_pkg::frame_t     command_bytes,
	output logic                frame_done
);

	import cdd_pkg::*;

	localparam int DLY_W = $clog2(REQ_DELAY + 1);
	localparam byte_idx_t LAST_IDX = byte_idx_t'(FRAME_BYTES - 1);

	seq_state_t       state;
	byte_idx_t        byte_idx;
	logic [DLY_W-1:0] delay_cnt;

	// Status byte for the current position
	assign tx_byte = status_bytes[byte_idx*8 +: 8];

	//////////////////////////////
	// Sequencer FSM
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		load <= 1'b0;
		clear <= 1'b0;
		frame_done <= 1'b0;
		if (reset) begin
			state <= SEQ_IDLE;
			byte_idx <= '0;
			delay_cnt <= '0;
			comreq_n <= 1'b1;
			comsync_n <= 1'b1;
		end else if (start) begin
			// New frame wins over any exchange in progress
			state <= SEQ_WAIT;
			byte_idx <= '0;
			delay_cnt <= DLY_W'(REQ_DELAY);
			load <= 1'b1;
			clear <= 1'b1;
			comreq_n <= 1'b1;
			comsync_n <= 1'b0;
		end else begin
			case (state)
				SEQ_WAIT: begin
					delay_cnt <= delay_cnt - 1'b1;
					if (delay_cnt == DLY_W'(1)) begin
						comreq_n <= 1'b0;
						state <= SEQ_XFER;
					end
				end

				SEQ_XFER: begin
					// Console has taken the request
					if (rx_edge)
						comreq_n <= 1'b1;
					if (byte_done) begin
						comsync_n <= 1'b1;
						if (byte_idx == LAST_IDX) begin
							frame_done <= 1'b1;
							state <= SEQ_IDLE;
						end else begin
							byte_idx <= byte_idx + 1'b1;
							load <= 1'b1;
							delay_cnt <= DLY_W'(REQ_DELAY);
							state <= SEQ_WAIT;
						end
					end
				end

				default: ;
			endcase
		end
	end

	// Received command bytes
	always_ff @(posedge clk_sys) begin
		if (byte_done && state == SEQ_XFER)
			command_bytes[byte_idx*8 +: 8] <= rx_byte;
	end

	a_idx_in_frame: assert property (
		@(posedge clk_sys) disable iff (reset)
		byte_idx <= LAST_IDX
	) else $error("byte index past end of frame");

endmodule

`default_nettype wire

/* hdl/cdd_command_frame.sv */
// Command frame publisher, adds play and seek counts and flips the host toggle
`default_nettype none

module cdd_command_frame (
	input  wire                 clk_sys,
	input  wire                 reset,
	input  wire cdd_pkg::frame_t command_bytes,
	input  wire                 frame_done,
	output cdd_pkg::frame_t     command_frame,
	output logic                command_toggle
);

	import cdd_pkg::*;

	byte_t       play_cnt;
	byte_t       seek_cnt;
	frame_t      published;
	cdd_opcode_t opcode;

	assign opcode = cdd_opcode_t'(command_bytes[7:0]);

	// Counts as they stood before this frame
	always_comb begin
		published = command_bytes;
		published[CNT_PLAY_BYTE*8 +: 8] = play_cnt;
		published[CNT_SEEK_BYTE*8 +: 8] = seek_cnt;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			play_cnt <= '0;
			seek_cnt <= '0;
			command_toggle <= 1'b0;
		end else if (frame_done) begin
			command_toggle <= ~command_toggle;
			case (opcode)
				OP_PLAY: play_cnt <= play_cnt + 8'd1;
				OP_SEEK: seek_cnt <= seek_cnt + 8'd1;
				OP_NOP:  ;	// idle poll, nothing to count
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (frame_done)
			command_frame <= published;
	end

endmodule

`default_nettype wire

/* hdl/cd_sector_feed.sv */
// CD sector feed, turns the host image download into flagged sector words
`default_nettype none

module cd_sector_feed (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     dl_active,
	input  wire                     dl_wr,
	input  wire [15:0]              dl_data,
	output cdd_pkg::sector_word_t   sector_word,
	output logic                    sector_wr
);

	typedef enum logic [1:0] {
		FEED_HDR    = 2'd0,
		FEED_READY  = 2'd1,
		FEED_STROBE = 2'd2
	} feed_state_t;

	feed_state_t state;
	logic        strobe_cnt;
	logic        audio_flag;
	logic        speed_flag;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= FEED_HDR;
			strobe_cnt <= 1'b0;
			sector_wr <= 1'b0;
		end else begin
			case (state)
				FEED_HDR: begin
					if (dl_active && dl_wr)
						state <= FEED_READY;
				end

				FEED_READY: begin
					if (!dl_active) begin
						state <= FEED_HDR;
					end else if (dl_wr) begin
						sector_wr <= 1'b1;
						strobe_cnt <= 1'b1;
						state <= FEED_STROBE;
					end
				end

				FEED_STROBE: begin
					// Two-cycle strobe, extra writes dropped
					strobe_cnt <= 1'b0;
					if (!strobe_cnt) begin
						sector_wr <= 1'b0;
						state <= FEED_READY;
					end
				end

				default: state <= FEED_HDR;
			endcase
		end
	end

	//////////////////////////////
	// Header flags and data word
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (state == FEED_HDR && dl_active && dl_wr) begin
			audio_flag <= dl_data[1];
			speed_flag <= dl_data[0];
		end
		// Byte swap of the host word
		if (state == FEED_READY && dl_active && dl_wr)
			sector_word <= {audio_flag, speed_flag, dl_data[7:0], dl_data[15:8]};
	end

endmodule

`default_nettype wire

/* hdl/cdd_bridge_top.sv */
// CD drive bridge top level, links host status and command frames to the console
`default_nettype none

module cdd_bridge_top #(
	parameter int START_DELAY = 15,
	parameter int REQ_DELAY   = 1023
) (
	input  wire                      clk_sys,
	input  wire                      reset,

	// Host side
	input  wire cdd_pkg::frame_t      status_frame,
	input  wire                      status_toggle,
	output cdd_pkg::frame_t          command_frame,
	output logic                     command_toggle,
	input  wire                      dl_active,
	input  wire                      dl_wr,
	input  wire [15:0]               dl_data,
	output cdd_pkg::sector_word_t    sector_word,
	output logic                     sector_wr,

	// Console side
	input  wire                      comclk,
	input  wire                      hdata,
	output logic                     cdata,
	output logic                     comreq_n,
	output logic                     comsync_n
);

	import cdd_pkg::*;

	frame_t status_bytes;
	frame_t command_bytes;
	byte_t  tx_byte;
	byte_t  rx_byte;
	logic   start;
	logic   load;
	logic   clear;
	logic   rx_edge;
	logic   byte_done;
	logic   frame_done;

	//////////////////////////////
	// Status and serial link
	//////////////////////////////
	cdd_status_launch #(
		.START_DELAY (START_DELAY)
	) launch_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.status_frame  (status_frame),
		.status_toggle (status_toggle),
		.status_bytes  (status_bytes),
		.start         (start)
	);

	cdd_byte_sequencer #(
		.REQ_DELAY (REQ_DELAY)
	) seq_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.start         (start),
		.status_bytes  (status_bytes),
		.rx_byte       (rx_byte),
		.rx_edge       (rx_edge),
		.byte_done     (byte_done),
		.load          (load),
		.clear         (clear),
		.tx_byte       (tx_byte),
		.comreq_n      (comreq_n),
		.comsync_n     (comsync_n),
		.command_bytes (command_bytes),
		.frame_done    (frame_done)
	);

	cdd_bit_shifter shifter_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.clear     (clear),
		.load      (load),
		.tx_byte   (tx_byte),
		.comclk    (comclk),
		.hdata     (hdata),
		.cdata     (cdata),
		.rx_byte   (rx_byte),
		.rx_edge   (rx_edge),
		.byte_done (byte_done)
	);

	cdd_command_frame cmd_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.command_bytes  (command_bytes),
		.frame_done     (frame_done),
		.command_frame  (command_frame),
		.command_toggle (command_toggle)
	);

	// Image download path
	cd_sector_feed feed_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active   (dl_active),
		.dl_wr       (dl_wr),
		.dl_data     (dl_data),
		.sector_word (sector_word),
		.sector_wr   (sector_wr)
	);

endmodule

`default_nettype wire

/* tb/cdd_bridge_tb.sv */
// CD drive bridge testbench, console link model with directed status, command and feed tests
`default_nettype none

module cdd_bridge_tb;

	import cdd_pkg::*;

	localparam int START_DELAY = 15;
	localparam int REQ_DELAY   = 31;
	// Console comclk half period in clk_sys cycles
	localparam int HALF        = 8;
	// Request delay, sixteen half periods and synchronizer slack per byte
	localparam int BYTE_CYCLES = REQ_DELAY + 16 * HALF + 24;
	localparam int EXCHANGES   = 6;
	localparam int MAX_CYCLES  = 2 * EXCHANGES * FRAME_BYTES * BYTE_CYCLES + 2000;

	logic         clk_sys;
	logic         reset;
	frame_t       status_frame;
	logic         status_toggle;
	frame_t       command_frame;
	logic         command_toggle;
	logic         dl_active;
	logic         dl_wr;
	logic [15:0]  dl_data;
	sector_word_t sector_word;
	logic         sector_wr;
	logic         comclk;
	logic         hdata;
	logic         cdata;
	logic         comreq_n;
	logic         comsync_n;

	integer seed = 32'h84a8_f617;
	int     errors = 0;
	int     checks = 0;
	int     cycle_cnt = 0;
	// Console side copy of the opcode counts and the host toggle
	byte_t  model_play;
	byte_t  model_seek;
	logic   model_toggle;

	cdd_bridge_top #(
		.START_DELAY (START_DELAY),
		.REQ_DELAY   (REQ_DELAY)
	) dut_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.status_frame   (status_frame),
		.status_toggle  (status_toggle),
		.command_frame  (command_frame),
		.command_toggle (command_toggle),
		.dl_active      (dl_active),
		.dl_wr          (dl_wr),
		.dl_data        (dl_data),
		.sector_word    (sector_word),
		.sector_wr      (sector_wr),
		.comclk         (comclk),
		.hdata          (hdata),
		.cdata          (cdata),
		.comreq_n       (comreq_n),
		.comsync_n      (comsync_n)
	);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the bridge stopped responding", cycle_cnt);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// Helpers and compares
	//////////////////////////////
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected %02h, actual %02h", name, exp, act);
		end
	endtask

	task automatic check_frame(input string name, input frame_t exp, input frame_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected %024h, actual %024h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_sector(input string name, input sector_word_t exp,
			input sector_word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected %05h, actual %05h", name, exp, act);
		end
	endtask

	task automatic random_frame(output frame_t f);
		f = {$random(seed), $random(seed), $random(seed)};
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		status_toggle = 1'b0;
		comclk = 1'b1;
		hdata = 1'b0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_data = '0;
		repeat (16) next_cycle();
		reset = 1'b0;
		model_play = '0;
		model_seek = '0;
		model_toggle = 1'b0;
		// comclk idles high, give the synchronizer time to follow
		repeat (4) next_cycle();
	endtask

	// Sent bytes with the counts from before this frame in bytes 9 and 8
	function automatic frame_t expected_command(input frame_t sent, input byte_t play,
			input byte_t seek);
		frame_t f;
		f = sent;
		f[int'(CNT_PLAY_BYTE) * 8 +: 8] = play;
		f[int'(CNT_SEEK_BYTE) * 8 +: 8] = seek;
		return f;
	endfunction

	//////////////////////////////
	// Console model
	//////////////////////////////
	task automatic console_exchange(input frame_t cmd, output frame_t got,
			output logic [FRAME_BYTES-1:0] sync_lo, output logic [FRAME_BYTES-1:0] sync_hi);
		for (int b = 0; b < FRAME_BYTES; b++) begin
			sync_lo[b] = 1'b1;
			sync_hi[b] = 1'b1;
			while (comreq_n)
				next_cycle();
			for (int k = 0; k < 8; k++) begin
				// Falling edge moves the bridge to the next bit
				comclk = 1'b0;
				hdata = cmd[b*8 + k];
				repeat (HALF) next_cycle();
				comclk = 1'b1;
				got[b*8 + k] = cdata;
				sync_lo[b] = sync_lo[b] & ~comsync_n;
				sync_hi[b] = sync_hi[b] & comsync_n;
				repeat (HALF) next_cycle();
			end
		end
	endtask

	task automatic run_exchange(input string name, input frame_t cmd);
		frame_t                 status;
		frame_t                 got;
		logic [FRAME_BYTES-1:0] sync_lo;
		logic [FRAME_BYTES-1:0] sync_hi;
		int                     wait_cycles;

		random_frame(status);
		status_frame = status;
		status_toggle = ~status_toggle;
		console_exchange(cmd, got, sync_lo, sync_hi);
		for (int b = 0; b < FRAME_BYTES; b++) begin
			check_byte($sformatf("%s status byte %0d", name, b),
				status[b*8 +: 8], got[b*8 +: 8]);
			if (b == 0)
				check_bit($sformatf("%s comsync_n low byte 0", name), 1'b1, sync_lo[b]);
			else
				check_bit($sformatf("%s comsync_n high byte %0d", name, b), 1'b1, sync_hi[b]);
		end
		// Toggle follows the last byte within a few cycles
		wait_cycles = 0;
		while (command_toggle === model_toggle && wait_cycles < 16) begin
			next_cycle();
			wait_cycles++;
		end
		model_toggle = ~model_toggle;
		check_bit($sformatf("%s command_toggle", name), model_toggle, command_toggle);
		check_frame($sformatf("%s command_frame", name),
			expected_command(cmd, model_play, model_seek), command_frame);
		if (cmd[7:0] == OP_PLAY)
			model_play = model_play + 8'd1;
		else if (cmd[7:0] == OP_SEEK)
			model_seek = model_seek + 8'd1;
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic test_reset_state();
		logic req_seen;

		check_bit("reset comreq_n", 1'b1, comreq_n);
		check_bit("reset comsync_n", 1'b1, comsync_n);
		check_bit("reset cdata", 1'b0, cdata);
		check_bit("reset command_toggle", 1'b0, command_toggle);
		check_bit("reset sector_wr", 1'b0, sector_wr);
		req_seen = 1'b0;
		repeat (200) begin
			next_cycle();
			if (!comreq_n)
				req_seen = 1'b1;
		end
		check_bit("idle request raised", 1'b0, req_seen);
	endtask

	task automatic test_status_and_command();
		frame_t cmd;

		random_frame(cmd);
		run_exchange("status", cmd);
	endtask

	task automatic test_counters();
		frame_t cmd;

		apply_reset();
		random_frame(cmd);
		cmd[7:0] = OP_PLAY;
		run_exchange("count play 1", cmd);
		random_frame(cmd);
		cmd[7:0] = OP_SEEK;
		run_exchange("count seek", cmd);
		random_frame(cmd);
		cmd[7:0] = OP_PLAY;
		run_exchange("count play 2", cmd);
		random_frame(cmd);
		cmd[7:0] = OP_NOP;
		run_exchange("count read", cmd);
		check_byte("play count", 8'd2, command_frame[int'(CNT_PLAY_BYTE) * 8 +: 8]);
		check_byte("seek count", 8'd1, command_frame[int'(CNT_SEEK_BYTE) * 8 +: 8]);
		// Counts must clear with the bridge
		apply_reset();
		random_frame(cmd);
		cmd[7:0] = OP_NOP;
		run_exchange("count after reset", cmd);
		check_byte("play count after reset", 8'd0, command_frame[int'(CNT_PLAY_BYTE) * 8 +: 8]);
		check_byte("seek count after reset", 8'd0, command_frame[int'(CNT_SEEK_BYTE) * 8 +: 8]);
	endtask

	task automatic test_sector_feed();
		logic [15:0]  hdr;
		logic [15:0]  word;
		sector_word_t exp;

		hdr = 16'h0003;
		dl_active = 1'b1;
		dl_wr = 1'b1;
		dl_data = hdr;
		next_cycle();
		dl_wr = 1'b0;
		check_bit("header sector_wr", 1'b0, sector_wr);
		repeat (3) next_cycle();
		for (int n = 0; n < 4; n++) begin
			word = 16'($random(seed));
			exp = {hdr[1], hdr[0], word[7:0], word[15:8]};
			dl_wr = 1'b1;
			dl_data = word;
			next_cycle();
			dl_wr = 1'b0;
			check_sector($sformatf("sector word %0d", n), exp, sector_word);
			// Six cycles until the next word, strobe only in the first two
			for (int c = 0; c < 6; c++) begin
				check_bit($sformatf("sector %0d sector_wr cycle %0d", n, c), (c < 2), sector_wr);
				if (c < 5)
					next_cycle();
			end
		end
		dl_active = 1'b0;
		repeat (2) next_cycle();
	endtask

	initial begin
		status_frame = '0;
		apply_reset();
		test_reset_state();
		test_status_and_command();
		test_counters();
		test_sector_feed();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hdl/cdd_pkg.sv
hdl/cdd_status_launch.sv
hdl/cdd_bit_shifter.sv
hdl/cdd_byte_sequencer.sv
hdl/cdd_command_frame.sv
hdl/cd_sector_feed.sv
hdl/cdd_bridge_top.sv
tb/cdd_bridge_tb.sv

/* Makefile */
# Verilator build and run for the CD drive bridge testbench

VERILATOR ?= verilator
TOP       ?= cdd_bridge_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The recipe status is the status of the final grep
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
